//--- run_sim.sh
#!/usr/bin/env bash
# builds the uno player testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f uno_player.f \
    --top-module uno_player_tb -o uno_player_sim || { echo "build failed"; exit 1; }
out="$(./obj_dir/uno_player_sim 2>&1)"
echo "$out"
echo "$out" | grep -qx "NO ERRORS" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- uno_card_picker.sv
`include "uno_defs.svh"

module uno_card_picker import uno_pkg::*; (
    input  card_t     i_prev_card,
    input  hand_sum_t i_sum,
    output pick_t     o_pick
);

    // index of the lowest set bit, zero when the vector is empty
    function automatic logic [3:0] first_set(input logic [`UNO_NUM_VALUES-1:0] vec);
        logic [3:0] idx;
        idx = '0;
        for (int i = `UNO_NUM_VALUES - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = 4'(i);
            end
        end
        return idx;
    endfunction

    color_e                     prev_color;
    logic [3:0]                 prev_value;
    logic                       value_ok;
    logic [3:0]                 value_idx;
    logic [`UNO_NUM_VALUES-1:0] color_row;
    logic [`UNO_NUM_COLORS-1:0] value_col;
    logic [`UNO_NUM_COLORS-1:0] other_colors;
    logic [3:0]                 row_idx;
    logic [3:0]                 col_idx;
    logic [3:0]                 other_idx;
    color_e                     wild_color;

    assign prev_color = i_prev_card.color;
    assign prev_value = i_prev_card.value;
    assign value_ok   = prev_value < 4'(`UNO_NUM_VALUES); // wilds have no value match
    assign value_idx  = value_ok ? prev_value : 4'd0;

    assign color_row = i_sum.rows[prev_color];

    always_comb begin
        for (int c = 0; c < `UNO_NUM_COLORS; c++) begin
            value_col[c] = i_sum.rows[c][value_idx];
        end
    end

    assign other_colors = i_sum.color_present & ~(4'b0001 << prev_color);

    assign row_idx   = first_set(color_row);
    assign col_idx   = first_set({{(`UNO_NUM_VALUES-`UNO_NUM_COLORS){1'b0}}, value_col});
    assign other_idx = first_set({{(`UNO_NUM_VALUES-`UNO_NUM_COLORS){1'b0}}, other_colors});

    // declare a colour we hold, falling back to the current one
    assign wild_color = (|other_colors) ? color_e'(other_idx[1:0]) : prev_color;

    always_comb begin
        o_pick = '0;
        if (i_sum.color_present[prev_color]) begin
            o_pick.valid      = 1'b1;
            o_pick.card.color = prev_color;
            o_pick.card.value = row_idx;
        end else if (value_ok && i_sum.value_present[value_idx]) begin
            o_pick.valid      = 1'b1;
            o_pick.card.color = color_e'(col_idx[1:0]);
            o_pick.card.value = prev_value;
        end else if (i_sum.wild) begin
            o_pick.valid      = 1'b1;
            o_pick.card.color = wild_color;
            o_pick.card.value = 4'(`UNO_WILD_VALUE);
        end else if (i_sum.wild4) begin
            o_pick.valid      = 1'b1;
            o_pick.card.color = wild_color;
            o_pick.card.value = 4'(`UNO_WILD4_VALUE);
        end
    end

endmodule

//--- uno_defs.svh
`ifndef UNO_DEFS_SVH
`define UNO_DEFS_SVH

// deck layout
`define UNO_NUM_COLORS    4
`define UNO_NUM_VALUES    13   // 0-9 numbers, 10-12 action cards
`define UNO_WILD_VALUE    13
`define UNO_WILD4_VALUE   14

// opening deal size
`define UNO_INIT_HAND     7

// number cards score their own value
`define UNO_ACTION_SCORE  20
`define UNO_WILD_SCORE    50

// register widths
`define UNO_HAND_NUM_W    7
`define UNO_SCORE_W       11
`define UNO_DRAW_CNT_W    3    // enough for the seven-card deal

`endif

//--- uno_hand.sv
`include "uno_defs.svh"

module uno_hand import uno_pkg::*; (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic                       i_add,
    input  card_t                      i_add_card,
    input  logic                       i_remove,
    input  card_t                      i_remove_card,
    output hand_sum_t                  o_sum,
    output logic [`UNO_HAND_NUM_W-1:0] o_hand_num,
    output logic [`UNO_SCORE_W-1:0]    o_score
);

    function automatic logic [`UNO_SCORE_W-1:0] card_score(input logic [3:0] value);
        if (value >= 4'(`UNO_WILD_VALUE)) begin
            return `UNO_WILD_SCORE;
        end else if (value >= 4'd10) begin
            return `UNO_ACTION_SCORE;
        end
        return {{(`UNO_SCORE_W-4){1'b0}}, value};
    endfunction

    // counts saturate at 3 in both directions
    function automatic logic [1:0] sat_inc(input logic [1:0] cnt);
        return (cnt == 2'd3) ? cnt : cnt + 2'd1;
    endfunction

    function automatic logic [1:0] sat_dec(input logic [1:0] cnt);
        return (cnt == 2'd0) ? cnt : cnt - 2'd1;
    endfunction

    logic [`UNO_NUM_COLORS-1:0][`UNO_NUM_VALUES-1:0][1:0] cnt_q, cnt_d;
    logic [1:0]                 wild_cnt_q, wild_cnt_d;
    logic [1:0]                 wild4_cnt_q, wild4_cnt_d;
    logic [`UNO_HAND_NUM_W-1:0] hand_num_q;
    logic [`UNO_SCORE_W-1:0]    score_q;

    always_comb begin
        cnt_d       = cnt_q;
        wild_cnt_d  = wild_cnt_q;
        wild4_cnt_d = wild4_cnt_q;
        if (i_add) begin
            if (i_add_card.value == 4'(`UNO_WILD_VALUE)) begin
                wild_cnt_d = sat_inc(wild_cnt_q);
            end else if (i_add_card.value == 4'(`UNO_WILD4_VALUE)) begin
                wild4_cnt_d = sat_inc(wild4_cnt_q);
            end
        end else if (i_remove) begin
            // declared colour of a wild is ignored here
            if (i_remove_card.value == 4'(`UNO_WILD_VALUE)) begin
                wild_cnt_d = sat_dec(wild_cnt_q);
            end else if (i_remove_card.value == 4'(`UNO_WILD4_VALUE)) begin
                wild4_cnt_d = sat_dec(wild4_cnt_q);
            end
        end
        for (int c = 0; c < `UNO_NUM_COLORS; c++) begin
            for (int v = 0; v < `UNO_NUM_VALUES; v++) begin
                if (i_add && i_add_card.color == color_e'(c) && i_add_card.value == 4'(v)) begin
                    cnt_d[c][v] = sat_inc(cnt_q[c][v]);
                end else if (i_remove && i_remove_card.color == color_e'(c)
                             && i_remove_card.value == 4'(v)) begin
                    cnt_d[c][v] = sat_dec(cnt_q[c][v]);
                end
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cnt_q       <= '0;
            wild_cnt_q  <= '0;
            wild4_cnt_q <= '0;
            hand_num_q  <= '0;
            score_q     <= '0;
        end else begin
            cnt_q       <= cnt_d;
            wild_cnt_q  <= wild_cnt_d;
            wild4_cnt_q <= wild4_cnt_d;
            if (i_add) begin
                hand_num_q <= hand_num_q + 1'b1;
                score_q    <= score_q + card_score(i_add_card.value);
            end else if (i_remove) begin
                hand_num_q <= hand_num_q - 1'b1;
                score_q    <= score_q - card_score(i_remove_card.value);
            end
        end
    end

    // presence summary straight from the count registers
    always_comb begin
        o_sum = '0;
        for (int c = 0; c < `UNO_NUM_COLORS; c++) begin
            for (int v = 0; v < `UNO_NUM_VALUES; v++) begin
                o_sum.rows[c][v] = |cnt_q[c][v];
            end
            o_sum.color_present[c] = |o_sum.rows[c];
        end
        for (int v = 0; v < `UNO_NUM_VALUES; v++) begin
            for (int c = 0; c < `UNO_NUM_COLORS; c++) begin
                o_sum.value_present[v] = o_sum.value_present[v] | o_sum.rows[c][v];
            end
        end
        o_sum.wild  = |wild_cnt_q;
        o_sum.wild4 = |wild4_cnt_q;
    end

    assign o_hand_num = hand_num_q;
    assign o_score    = score_q;

endmodule

//--- uno_pkg.sv
`include "uno_defs.svh"

package uno_pkg;

    typedef enum logic [1:0] {
        COLOR_RED    = 2'd0,
        COLOR_YELLOW = 2'd1,
        COLOR_GREEN  = 2'd2,
        COLOR_BLUE   = 2'd3
    } color_e;

    // for a wild card the colour carries the declared colour
    typedef struct packed {
        color_e     color;
        logic [3:0] value;
    } card_t;

    typedef struct packed {
        logic [`UNO_NUM_COLORS-1:0]                       color_present;
        logic [`UNO_NUM_VALUES-1:0]                       value_present; // any colour
        logic [`UNO_NUM_COLORS-1:0][`UNO_NUM_VALUES-1:0] rows;          // per colour
        logic                                             wild;
        logic                                             wild4;
    } hand_sum_t;

    typedef struct packed {
        logic  valid;   // a legal card exists
        card_t card;
    } pick_t;

endpackage

//--- uno_player.f
+incdir+.
uno_pkg.sv
uno_hand.sv
uno_card_picker.sv
uno_turn_fsm.sv
uno_player.sv
uno_player_chk.sv
uno_player_tb.sv

//--- uno_player.sv
`include "uno_defs.svh"

module uno_player import uno_pkg::*; (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic                       i_init,
    input  logic                       i_start,
    input  logic                       i_draw_two,
    input  logic                       i_draw_four,
    input  logic                       i_drawn,
    input  logic                       i_check,
    input  card_t                      i_prev_card,
    input  card_t                      i_drawed_card,
    output card_t                      o_out_card,
    output logic                       o_out,
    output logic                       o_draw_card,
    output logic                       o_turn_done,
    output logic [`UNO_HAND_NUM_W-1:0] o_hand_num,
    output logic [`UNO_SCORE_W-1:0]    o_score
);

    hand_sum_t sum;
    pick_t     pick;
    logic      add;
    logic      remove;
    card_t     add_card;
    card_t     remove_card;

    uno_hand hand_i (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_add         (add),
        .i_add_card    (add_card),
        .i_remove      (remove),
        .i_remove_card (remove_card),
        .o_sum         (sum),
        .o_hand_num    (o_hand_num),
        .o_score       (o_score)
    );

    uno_card_picker picker_i (
        .i_prev_card (i_prev_card),
        .i_sum       (sum),
        .o_pick      (pick)
    );

    uno_turn_fsm fsm_i (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_init        (i_init),
        .i_start       (i_start),
        .i_draw_two    (i_draw_two),
        .i_draw_four   (i_draw_four),
        .i_drawn       (i_drawn),
        .i_check       (i_check),
        .i_drawed_card (i_drawed_card),
        .i_pick        (pick),
        .o_add         (add),
        .o_remove      (remove),
        .o_add_card    (add_card),
        .o_remove_card (remove_card),
        .o_draw_card   (o_draw_card),
        .o_out         (o_out),
        .o_turn_done   (o_turn_done),
        .o_out_card    (o_out_card)
    );

endmodule

//--- uno_player_chk.sv
module uno_player_chk import uno_pkg::*; (
    input logic  i_clk,
    input logic  i_rst_n,
    input logic  i_check,
    input logic  i_out,
    input logic  i_draw_card,
    input logic  i_turn_done,
    input card_t i_out_card
);

    // a card is either offered or requested
    out_vs_draw: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_out && i_draw_card))
        else $error("o_out and o_draw_card high in the same cycle");

    out_card_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_out && !i_check) |=> (i_out && $stable(i_out_card)))
        else $error("played card dropped or changed before i_check");

    out_release: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_out && i_check) |=> (!i_out && i_out_card == '0))
        else $error("o_out not released the cycle after i_check");

    turn_done_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_turn_done |=> !i_turn_done)
        else $error("o_turn_done longer than one cycle");

endmodule

bind uno_player uno_player_chk chk_i (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_check     (i_check),
    .i_out       (o_out),
    .i_draw_card (o_draw_card),
    .i_turn_done (o_turn_done),
    .i_out_card  (o_out_card)
);

//--- uno_player_tb.sv
`include "uno_defs.svh"

module uno_player_tb import uno_pkg::*; ();

    localparam int    NUM_ROWS = 8;
    localparam int    TIMEOUT  = 200;  // cycles allowed for each wait
    localparam card_t NO_CARD  = '0;

    typedef struct packed {
        logic                       deal;       // opening deal instead of a turn
        logic                       draw_two;
        logic                       draw_four;
        card_t                      prev;
        logic [2:0]                 n_cards;
        card_t [0:6]                cards;      // delivered in index order
        logic                       play;
        card_t                      exp_card;
        logic [`UNO_HAND_NUM_W-1:0] exp_num;
        logic [`UNO_SCORE_W-1:0]    exp_score;
    } row_t;

    logic                       i_clk = 1'b0;
    logic                       i_rst_n;
    logic                       i_init;
    logic                       i_start;
    logic                       i_draw_two;
    logic                       i_draw_four;
    logic                       i_drawn;
    logic                       i_check;
    card_t                      i_prev_card;
    card_t                      i_drawed_card;
    card_t                      o_out_card;
    logic                       o_out;
    logic                       o_draw_card;
    logic                       o_turn_done;
    logic [`UNO_HAND_NUM_W-1:0] o_hand_num;
    logic [`UNO_SCORE_W-1:0]    o_score;

    row_t  rows  [NUM_ROWS];
    string names [NUM_ROWS];
    string cur_name;
    int    test_errs;
    int    total_errs   = 0;
    int    tests_run    = 0;
    int    tests_failed = 0;

    uno_player dut_i (.*);

    always #10 i_clk = ~i_clk;

    function automatic card_t crd(input color_e c, input int v);
        card_t k;
        k.color = c;
        k.value = 4'(v);
        return k;
    endfunction

    // hand carries over from row to row, so sizes and scores accumulate
    function automatic void load_table();
        // deal, draw_two, draw_four, prev, count, cards, play, played card, size, score
        names[0] = "opening_deal";
        rows[0]  = '{1'b1, 1'b0, 1'b0, NO_CARD, 3'd7,
                     {crd(COLOR_RED, 3), crd(COLOR_YELLOW, 5), crd(COLOR_GREEN, 7),
                      crd(COLOR_RED, 7), crd(COLOR_YELLOW, 10), crd(COLOR_RED, 13),
                      crd(COLOR_RED, 14)},
                     1'b0, NO_CARD, 7'd7, 11'd142};
        names[1] = "color_match";
        rows[1]  = '{1'b0, 1'b0, 1'b0, crd(COLOR_YELLOW, 1), 3'd0, {7{NO_CARD}},
                     1'b1, crd(COLOR_YELLOW, 5), 7'd6, 11'd137};
        names[2] = "value_match";
        rows[2]  = '{1'b0, 1'b0, 1'b0, crd(COLOR_BLUE, 7), 3'd0, {7{NO_CARD}},
                     1'b1, crd(COLOR_RED, 7), 7'd5, 11'd130};
        names[3] = "wild_declare";  // red is the lowest colour held besides blue
        rows[3]  = '{1'b0, 1'b0, 1'b0, crd(COLOR_BLUE, 4), 3'd0, {7{NO_CARD}},
                     1'b1, crd(COLOR_RED, 13), 7'd4, 11'd80};
        names[4] = "draw_two_play";
        rows[4]  = '{1'b0, 1'b1, 1'b0, crd(COLOR_BLUE, 9), 3'd2,
                     {crd(COLOR_BLUE, 1), crd(COLOR_GREEN, 3), {5{NO_CARD}}},
                     1'b1, crd(COLOR_BLUE, 1), 7'd5, 11'd83};
        names[5] = "wild4_only";
        rows[5]  = '{1'b0, 1'b0, 1'b0, crd(COLOR_BLUE, 6), 3'd0, {7{NO_CARD}},
                     1'b1, crd(COLOR_RED, 14), 7'd4, 11'd33};
        names[6] = "no_legal_card";
        rows[6]  = '{1'b0, 1'b0, 1'b0, crd(COLOR_BLUE, 8), 3'd1,
                     {crd(COLOR_BLUE, 11), {6{NO_CARD}}},
                     1'b0, NO_CARD, 7'd5, 11'd53};
        names[7] = "draw_four_play";
        rows[7]  = '{1'b0, 1'b0, 1'b1, crd(COLOR_YELLOW, 12), 3'd4,
                     {crd(COLOR_RED, 12), crd(COLOR_BLUE, 0), crd(COLOR_YELLOW, 2),
                      crd(COLOR_GREEN, 9), {3{NO_CARD}}},
                     1'b1, crd(COLOR_YELLOW, 2), 7'd8, 11'd82};
    endfunction

    task automatic check_value(input string what, input int exp, input int act);
        assert (exp == act) else begin
            $display("FAILED %s: %s expected %0h actual %0h", cur_name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic wait_draw_request(output logic ok);
        int cnt;
        cnt = 0;
        while (!o_draw_card && cnt < TIMEOUT) begin
            @(negedge i_clk);
            cnt++;
        end
        ok = o_draw_card;
        assert (ok) else begin
            $display("test %s: the player never asked for a card", cur_name);
            test_errs++;
        end
    endtask

    task automatic deliver_card(input card_t card, output logic ok);
        int idle;
        wait_draw_request(ok);
        if (!ok) begin
            return;
        end
        idle = $urandom % 6;
        repeat (idle) @(posedge i_clk);
        @(posedge i_clk);
        i_drawn       <= 1'b1;
        i_drawed_card <= card;
        @(posedge i_clk);  // transfer edge
        i_drawn       <= 1'b0;
        i_drawed_card <= NO_CARD;
        @(negedge i_clk);
    endtask

    task automatic wait_outcome(output logic ok);
        int cnt;
        cnt = 0;
        while (!o_out && !o_turn_done && cnt < TIMEOUT) begin
            @(negedge i_clk);
            cnt++;
        end
        ok = o_out | o_turn_done;
        assert (ok) else begin
            $display("test %s: the turn never ended with a play or a turn done", cur_name);
            test_errs++;
        end
    endtask

    task automatic accept_card();
        int idle;
        idle = $urandom % 6;
        repeat (idle) begin
            @(negedge i_clk);
            check_value("o_out held", 1, o_out);
        end
        @(posedge i_clk);
        i_check <= 1'b1;
        @(posedge i_clk);
        i_check <= 1'b0;
        @(negedge i_clk);
        check_value("o_out after i_check", 0, o_out);
        check_value("o_out_card after i_check", 0, o_out_card);
    endtask

    task automatic start_action(input row_t r);
        @(posedge i_clk);
        i_prev_card <= r.prev;  // held for the whole turn
        i_start     <= ~r.deal;
        i_init      <= r.deal;
        i_draw_two  <= r.draw_two;
        i_draw_four <= r.draw_four;
        @(posedge i_clk);
        i_start     <= 1'b0;
        i_init      <= 1'b0;
        i_draw_two  <= 1'b0;
        i_draw_four <= 1'b0;
        @(negedge i_clk);
    endtask

    task automatic run_row(input int idx);
        row_t r;
        logic ok;
        r         = rows[idx];
        cur_name  = names[idx];
        test_errs = 0;
        start_action(r);
        for (int k = 0; k < int'(r.n_cards); k++) begin
            deliver_card(r.cards[k], ok);
            if (!ok) begin
                return;
            end
        end
        if (r.n_cards != 0) begin
            check_value("o_draw_card after last card", 0, o_draw_card);
        end
        if (!r.deal) begin
            wait_outcome(ok);
            if (!ok) begin
                return;
            end
            check_value("play", r.play, o_out);
            if (o_out) begin
                check_value("o_out_card", r.exp_card, o_out_card);
                accept_card();
            end else begin
                @(negedge i_clk);
                check_value("o_turn_done one cycle later", 0, o_turn_done);
            end
        end
        check_value("o_hand_num", r.exp_num, o_hand_num);
        check_value("o_score", r.exp_score, o_score);
    endtask

    task automatic report_test();
        tests_run++;
        total_errs += test_errs;
        if (test_errs == 0) begin
            $display("test %s: passed", cur_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d checks failed", cur_name, test_errs);
        end
    endtask

    initial begin
        void'($urandom(32'hdf61_43df));
        i_rst_n       <= 1'b0;
        i_init        <= 1'b0;
        i_start       <= 1'b0;
        i_draw_two    <= 1'b0;
        i_draw_four   <= 1'b0;
        i_drawn       <= 1'b0;
        i_check       <= 1'b0;
        i_prev_card   <= NO_CARD;
        i_drawed_card <= NO_CARD;
        load_table();
        repeat (16) @(posedge i_clk);
        i_rst_n <= 1'b1;
        @(negedge i_clk);
        cur_name  = "reset_values";
        test_errs = 0;
        check_value("o_out", 0, o_out);
        check_value("o_draw_card", 0, o_draw_card);
        check_value("o_turn_done", 0, o_turn_done);
        check_value("o_out_card", 0, o_out_card);
        check_value("o_hand_num", 0, o_hand_num);
        check_value("o_score", 0, o_score);
        report_test();
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
            report_test();
        end
        $display("summary: %0d tests, %0d failed, %0d failed checks",
                 tests_run, tests_failed, total_errs);
        if (total_errs == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- uno_turn_fsm.sv
`include "uno_defs.svh"

module uno_turn_fsm import uno_pkg::*; (
    input  logic  i_clk,
    input  logic  i_rst_n,
    input  logic  i_init,
    input  logic  i_start,
    input  logic  i_draw_two,
    input  logic  i_draw_four,
    input  logic  i_drawn,
    input  logic  i_check,
    input  card_t i_drawed_card,
    input  pick_t i_pick,
    output logic  o_add,
    output logic  o_remove,
    output card_t o_add_card,
    output card_t o_remove_card,
    output logic  o_draw_card,
    output logic  o_out,
    output logic  o_turn_done,
    output card_t o_out_card
);

    localparam logic [2:0] S_IDLE   = 3'd0;
    localparam logic [2:0] S_DRAW   = 3'd1;
    localparam logic [2:0] S_SELECT = 3'd2;
    localparam logic [2:0] S_OUT    = 3'd3;
    localparam logic [2:0] S_NOCARD = 3'd4;

    localparam logic [`UNO_DRAW_CNT_W-1:0] DEAL_DRAWS  = `UNO_INIT_HAND;
    localparam logic [`UNO_DRAW_CNT_W-1:0] TWO_DRAWS   = 2;
    localparam logic [`UNO_DRAW_CNT_W-1:0] FOUR_DRAWS  = 4;
    localparam logic [`UNO_DRAW_CNT_W-1:0] NOCARD_DRAW = 1;

    logic [2:0]                 state_q;
    logic [`UNO_DRAW_CNT_W-1:0] pend_q;     // cards still wanted
    logic                       deal_q;     // draws belong to the opening deal
    logic                       draw_card_q;
    logic                       out_q;
    logic                       turn_done_q;
    card_t                      out_card_q;
    logic                       xfer;
    logic                       last_xfer;

    assign xfer      = draw_card_q & i_drawn;
    assign last_xfer = xfer && (pend_q == NOCARD_DRAW);

    assign o_add         = xfer;
    assign o_add_card    = i_drawed_card;
    assign o_remove      = (state_q == S_SELECT) && i_pick.valid;
    assign o_remove_card = i_pick.card;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q     <= S_IDLE;
            pend_q      <= '0;
            deal_q      <= 1'b0;
            draw_card_q <= 1'b0;
            out_q       <= 1'b0;
            turn_done_q <= 1'b0;
            out_card_q  <= '0;
        end else begin
            turn_done_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (i_start) begin  // a turn wins over a deal
                        deal_q <= 1'b0;
                        if (i_draw_two) begin
                            pend_q      <= TWO_DRAWS;
                            draw_card_q <= 1'b1;
                            state_q     <= S_DRAW;
                        end else if (i_draw_four) begin
                            pend_q      <= FOUR_DRAWS;
                            draw_card_q <= 1'b1;
                            state_q     <= S_DRAW;
                        end else begin
                            state_q <= S_SELECT;
                        end
                    end else if (i_init) begin
                        deal_q      <= 1'b1;
                        pend_q      <= DEAL_DRAWS;
                        draw_card_q <= 1'b1;
                        state_q     <= S_DRAW;
                    end
                end
                S_DRAW: begin
                    if (xfer) begin
                        pend_q <= pend_q - 1'b1;
                    end
                    if (last_xfer) begin
                        draw_card_q <= 1'b0;
                        state_q     <= deal_q ? S_IDLE : S_SELECT;
                    end
                end
                S_SELECT: begin
                    // hand removal happens in this same cycle
                    if (i_pick.valid) begin
                        out_q      <= 1'b1;
                        out_card_q <= i_pick.card;
                        state_q    <= S_OUT;
                    end else begin
                        pend_q      <= NOCARD_DRAW;
                        draw_card_q <= 1'b1;
                        state_q     <= S_NOCARD;
                    end
                end
                S_OUT: begin
                    if (i_check) begin
                        out_q      <= 1'b0;
                        out_card_q <= '0;
                        state_q    <= S_IDLE;
                    end
                end
                S_NOCARD: begin
                    if (last_xfer) begin  // drawn card is kept, turn ends
                        pend_q      <= pend_q - 1'b1;
                        draw_card_q <= 1'b0;
                        turn_done_q <= 1'b1;
                        state_q     <= S_IDLE;
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    assign o_draw_card = draw_card_q;
    assign o_out       = out_q;
    assign o_turn_done = turn_done_q;
    assign o_out_card  = out_card_q;

endmodule
